// File: include/cpu_board_consts.svh
/* Address field values, mailbox pages and bus constants
   shared by the CPU board glue */
`ifndef CPU_BOARD_CONSTS_SVH
`define CPU_BOARD_CONSTS_SVH

// --------------------
// Bus values
// --------------------
`define CB_IDLE_BYTE        8'hFF    // Undriven data bus reads as all ones

// --------------------
// Address decode
// --------------------
`define CB_IO_REGION        2'b11    // A15:A14, C000-FFFF region
`define CB_VIDEO_REG_PREFIX 5'b11001 // A15:A11, C800 register page group

// Mailbox pages, compared with A10:A8 inside the C000-C7FF block
`define CB_MBOX_PAGE_A      3'd7     // CPU A mailbox at C700
`define CB_MBOX_PAGE_B      3'd0     // CPU B mailbox at C000

// --------------------
// Board size
// --------------------
`define CB_NUM_CPUS         2        // CPU A and CPU B

`endif

// File: rtl/cpu_board_pkg.sv
/* Bus, status and video strobe types for the CPU board glue */
`default_nettype none

package cpu_board_pkg;

    typedef logic [15:0] cpu_addr_t;   // Z80 address
    typedef logic [7:0]  cpu_data_t;   // Data byte
    typedef logic [11:0] video_addr_t; // Shared video address bus
    typedef logic [1:0]  rom_bank_t;   // ROM socket 0..2

    // One CPU's outputs onto the board
    typedef struct packed {
        cpu_addr_t addr;
        cpu_data_t dout;
        logic      mreq_n;
        logic      rd_n;
        logic      wr_n;
        logic      iorq_n;
    } cpu_bus_t;

    // What the board hands back to one CPU
    typedef struct packed {
        cpu_data_t din;       // Registered data-in
        logic      irq_n;     // VBL interrupt
        logic      nmi_n;     // Mailbox NMI
        logic      window_en; // Shared video window hit
        rom_bank_t rom_bank;
        logic      rom_cs;
    } cpu_status_t;

    // Video register write strobes, active low, pages 0-4, 6, 7
    typedef struct packed {
        logic msb_n;
        logic fsx_n;
        logic fsy_n;
        logic b1sx_n;
        logic b1sy_n;
        logic side_bank_n;
        logic back1_bank_n;
    } video_strobes_t;

endpackage

`default_nettype wire

// File: rtl/video_read_latch.sv
/* Read-side latches on the shared video data bus, one per CPU */
`timescale 1ns/1ps
`default_nettype none

module video_read_latch (
    input  wire                      clk,
    input  wire                      RESETn,
    input  wire cpu_board_pkg::cpu_data_t v_in,   // Shared video read bus
    input  wire                      rla,         // Load enable, CPU A side
    input  wire                      rlb,         // Load enable, CPU B side
    output cpu_board_pkg::cpu_data_t latched [2]
);

    logic [1:0] load; // Bit i loads latched[i]

    assign load = {rlb, rla};

    // Transparent while enabled, sampled on clk; holds otherwise
    always_ff @(posedge clk) begin
        if (!RESETn) begin
            for (int i = 0; i < 2; i++) begin
                latched[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (load[i]) begin
                    latched[i] <= v_in;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/cpu_bus_port.sv
/* Per-CPU address decode, registered data-in mux,
   VBL interrupt latch and mailbox strobes */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_board_consts.svh"

module cpu_bus_port #(
    parameter logic [2:0] MBOX_PAGE = 3'd0 // A10:A8 of this CPU's mailbox
) (
    input  wire                          clk,
    input  wire                          RESETn,
    input  wire cpu_board_pkg::cpu_bus_t bus,
    input  wire cpu_board_pkg::cpu_data_t rom_rdata,
    input  wire cpu_board_pkg::cpu_data_t video_rdata, // From the read latch
    input  wire                          vbl,
    input  wire                          nmi_n,
    output cpu_board_pkg::cpu_status_t   status,
    output logic                         mbox_rd,
    output logic                         mbox_wr
);

    logic                     io_region;  // A15:A14 == 11
    logic                     rom_cs;
    logic                     window_en;
    logic                     mbox_sel;
    cpu_board_pkg::cpu_data_t din_q;
    logic                     vbl_q;      // VBL edge detect
    logic                     irq_n_q;

    // --------------------
    // Address decode
    // --------------------
    assign io_region = (bus.addr[15:14] == `CB_IO_REGION);
    assign rom_cs    = !bus.mreq_n && !io_region; // Sockets 0..2 below C000
    assign window_en = !bus.mreq_n && io_region && (bus.addr[13:11] != 3'b000);

    // Mailbox sits in the C000-C7FF block
    assign mbox_sel = io_region && (bus.addr[13:11] == 3'b000)
                      && (bus.addr[10:8] == MBOX_PAGE);
    assign mbox_rd  = mbox_sel && !bus.mreq_n && !bus.rd_n;
    assign mbox_wr  = mbox_sel && !bus.mreq_n && !bus.wr_n;

    // --------------------
    // Data-in and IRQ
    // --------------------
    always_ff @(posedge clk) begin
        if (!RESETn) begin
            din_q   <= '0;
            vbl_q   <= 1'b0;
            irq_n_q <= 1'b1;
        end else begin
            // Priority mux, ROM first
            if (rom_cs) begin
                din_q <= rom_rdata;
            end else if (mbox_rd) begin
                din_q <= `CB_IDLE_BYTE; // Mailbox read returns nothing
            end else if (!bus.rd_n && window_en) begin
                din_q <= video_rdata;
            end else begin
                din_q <= `CB_IDLE_BYTE;
            end

            vbl_q <= vbl;
            if (!bus.iorq_n) begin
                irq_n_q <= 1'b1;          // Acknowledge wins over a new edge
            end else if (vbl && !vbl_q) begin
                irq_n_q <= 1'b0;
            end
        end
    end

    always_comb begin
        status           = '0;
        status.din       = din_q;
        status.irq_n     = irq_n_q;
        status.nmi_n     = nmi_n;             // Straight from mailbox_nmi
        status.window_en = window_en;
        status.rom_bank  = bus.addr[15:14];
        status.rom_cs    = rom_cs;
    end

endmodule

`default_nettype wire

// File: rtl/mailbox_nmi.sv
/* Crossed NMI flip-flops between the two CPUs' mailboxes */
`timescale 1ns/1ps
`default_nettype none

module mailbox_nmi (
    input  wire  clk,
    input  wire  RESETn,
    input  wire  mbox_rd [2], // Mailbox read level per CPU
    input  wire  mbox_wr [2], // Mailbox write level per CPU
    output logic nmi_n   [2]
);

    logic rd_q [2]; // Previous read levels

    // End of a read by CPU 1-i triggers NMI on CPU i
    always_ff @(posedge clk) begin
        if (!RESETn) begin
            for (int i = 0; i < 2; i++) begin
                rd_q[i]  <= 1'b0;
                nmi_n[i] <= 1'b1;
            end
        end else begin
            for (int i = 0; i < 2; i++) begin
                rd_q[i] <= mbox_rd[i];
                if (mbox_wr[i]) begin
                    nmi_n[i] <= 1'b1;   // Own write acknowledges
                end else if (rd_q[1 - i] && !mbox_rd[1 - i]) begin
                    nmi_n[i] <= 1'b0;   // Other side's read just ended
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/video_bus_mux.sv
/* Shared video address and write-data select,
   video register write strobe decode */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_board_consts.svh"

module video_bus_mux (
    input  wire cpu_board_pkg::cpu_bus_t   bus_a,
    input  wire cpu_board_pkg::cpu_bus_t   bus_b,
    input  wire                            a_b,     // High selects CPU B
    input  wire                            wba,     // CPU A write enable, low active
    input  wire                            wbb,     // CPU B write enable, low active
    input  wire                            vdg,     // Strobe gate, low active
    output cpu_board_pkg::video_addr_t     va,
    output cpu_board_pkg::cpu_data_t       v_out,
    output cpu_board_pkg::video_strobes_t  strobes
);

    cpu_board_pkg::cpu_addr_t sel_addr; // Address of the CPU owning the bus
    logic                     reg_hit;

    assign sel_addr = a_b ? bus_b.addr : bus_a.addr;
    assign va       = sel_addr[11:0];

    // CPU A has priority on the write data
    assign v_out = !wba ? bus_a.dout :
                   !wbb ? bus_b.dout : `CB_IDLE_BYTE;

    assign reg_hit = !vdg && (sel_addr[15:11] == `CB_VIDEO_REG_PREFIX);

    // --------------------
    // C800-CF00 strobes
    // --------------------
    always_comb begin
        strobes = '1; // All idle high
        if (reg_hit) begin
            case (va[10:8])
                3'd0:    strobes.msb_n        = 1'b0;
                3'd1:    strobes.fsx_n        = 1'b0;
                3'd2:    strobes.fsy_n        = 1'b0;
                3'd3:    strobes.b1sx_n       = 1'b0;
                3'd4:    strobes.b1sy_n       = 1'b0;
                3'd6:    strobes.side_bank_n  = 1'b0;
                3'd7:    strobes.back1_bank_n = 1'b0;
                default: strobes = '1;          // CD00 unused
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/cpu_board_glue.sv
/* Top level of the two-CPU board glue: read latches,
   per-CPU bus ports, mailbox NMI and video bus mux */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_board_consts.svh"

module cpu_board_glue (
    input  wire                                clk,
    input  wire                                RESETn,
    input  wire cpu_board_pkg::cpu_bus_t       cpu_bus   [`CB_NUM_CPUS], // 0 = A, 1 = B
    input  wire cpu_board_pkg::cpu_data_t      rom_rdata [`CB_NUM_CPUS],
    input  wire                                vbl,
    input  wire                                a_b,
    input  wire                                wba,
    input  wire                                wbb,
    input  wire                                vdg,
    input  wire                                rla,
    input  wire                                rlb,
    input  wire cpu_board_pkg::cpu_data_t      v_in,
    output cpu_board_pkg::cpu_status_t         status    [`CB_NUM_CPUS],
    output cpu_board_pkg::video_addr_t         va,
    output cpu_board_pkg::cpu_data_t          v_out,
    output cpu_board_pkg::video_strobes_t      strobes
);

    cpu_board_pkg::cpu_data_t latched [`CB_NUM_CPUS];
    logic                     mbox_rd [`CB_NUM_CPUS];
    logic                     mbox_wr [`CB_NUM_CPUS];
    logic                     nmi_n   [`CB_NUM_CPUS];

    video_read_latch video_read_latch_inst (
        .clk    (clk),
        .RESETn (RESETn),
        .v_in   (v_in),
        .rla    (rla),
        .rlb    (rlb),
        .latched(latched)
    );

    // One port per CPU, mailbox page by index
    for (genvar i = 0; i < `CB_NUM_CPUS; i++) begin : g_cpu
        cpu_bus_port #(
            .MBOX_PAGE((i == 0) ? `CB_MBOX_PAGE_A : `CB_MBOX_PAGE_B)
        ) cpu_bus_port_inst (
            .clk        (clk),
            .RESETn     (RESETn),
            .bus        (cpu_bus[i]),
            .rom_rdata  (rom_rdata[i]),
            .video_rdata(latched[i]),
            .vbl        (vbl),
            .nmi_n      (nmi_n[i]),
            .status     (status[i]),
            .mbox_rd    (mbox_rd[i]),
            .mbox_wr    (mbox_wr[i])
        );
    end

    mailbox_nmi mailbox_nmi_inst (
        .clk    (clk),
        .RESETn (RESETn),
        .mbox_rd(mbox_rd),
        .mbox_wr(mbox_wr),
        .nmi_n  (nmi_n)
    );

    video_bus_mux video_bus_mux_inst (
        .bus_a  (cpu_bus[0]),
        .bus_b  (cpu_bus[1]),
        .a_b    (a_b),
        .wba    (wba),
        .wbb    (wbb),
        .vdg    (vdg),
        .va     (va),
        .v_out  (v_out),
        .strobes(strobes)
    );

endmodule

`default_nettype wire

// File: verification/tb_clock_gen.sv
/* Free-running testbench clock, 10 ns period */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk
);

    initial clk = 1'b0;
    always #5 clk = ~clk; // Half period

endmodule

`default_nettype wire

// File: verification/tb_cpu_board_glue.sv
/* Vector-driven testbench for the CPU board glue:
   reads rows, drives on the falling edge, checks before the next one */
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_board_glue;

    // One test step with its stimulus and expected outputs
    typedef struct packed {
        cpu_board_pkg::cpu_bus_t       bus_a;
        cpu_board_pkg::cpu_bus_t       bus_b;
        cpu_board_pkg::cpu_data_t      rom_a;
        cpu_board_pkg::cpu_data_t      rom_b;
        logic [6:0]                    ctl;   // vbl a_b wba wbb vdg rla rlb
        cpu_board_pkg::cpu_data_t      v_in;
        cpu_board_pkg::cpu_status_t    exp_a;
        cpu_board_pkg::cpu_status_t    exp_b;
        cpu_board_pkg::video_addr_t    exp_va;
        cpu_board_pkg::cpu_data_t      exp_vo;
        cpu_board_pkg::video_strobes_t exp_st;
    } step_t;

    logic                          clk;
    logic                          RESETn;
    cpu_board_pkg::cpu_bus_t       cpu_bus   [2];
    cpu_board_pkg::cpu_data_t      rom_rdata [2];
    logic                          vbl, a_b, wba, wbb, vdg, rla, rlb;
    cpu_board_pkg::cpu_data_t      v_in;
    cpu_board_pkg::cpu_status_t    status    [2];
    cpu_board_pkg::video_addr_t    va;
    cpu_board_pkg::cpu_data_t      v_out;
    cpu_board_pkg::video_strobes_t strobes;

    step_t steps[$];
    int    errors = 0;
    int    cycles = 0;
    int    cycle_limit = 1000; // Replaced once the rows are known

    tb_clock_gen clock_inst (.clk(clk));

    cpu_board_glue cpu_board_glue_inst (
        .clk(clk), .RESETn(RESETn), .cpu_bus(cpu_bus), .rom_rdata(rom_rdata),
        .vbl(vbl), .a_b(a_b), .wba(wba), .wbb(wbb), .vdg(vdg), .rla(rla),
        .rlb(rlb), .v_in(v_in), .status(status), .va(va), .v_out(v_out),
        .strobes(strobes)
    );

    // --------------------
    // Helpers
    // --------------------
    task automatic check_value(input string name, input logic [15:0] exp,
                               input logic [15:0] act);
        assert (act === exp) else begin
            errors++;
            $display("MISMATCH at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic load_steps();
        int    fd;
        int    n;
        int    f [31];
        string line;
        step_t s;
        fd = $fopen("verification/cpu_board_testdata.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the test data file");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") continue; // Blank or comment
            n = $sscanf(line,
                        "%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                        f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18],
                        f[19], f[20], f[21], f[22], f[23], f[24], f[25], f[26], f[27],
                        f[28], f[29], f[30]);
            if (n != 31) begin
                errors++;
                $display("Malformed data row %0d, only %0d fields read", steps.size(), n);
                break;
            end
            s.bus_a  = {f[0][15:0], f[1][7:0], f[2][3:0]};
            s.bus_b  = {f[3][15:0], f[4][7:0], f[5][3:0]};
            s.rom_a  = f[6][7:0];
            s.rom_b  = f[7][7:0];
            s.ctl    = {f[8][0], f[9][0], f[10][0], f[11][0], f[12][0], f[13][0], f[14][0]};
            s.v_in   = f[15][7:0];
            s.exp_a  = {f[16][7:0], f[17][0], f[18][0], f[19][0], f[20][1:0], f[21][0]};
            s.exp_b  = {f[22][7:0], f[23][0], f[24][0], f[25][0], f[26][1:0], f[27][0]};
            s.exp_va = f[28][11:0];
            s.exp_vo = f[29][7:0];
            s.exp_st = f[30][6:0];
            steps.push_back(s);
        end
        $fclose(fd);
        if (steps.size() == 0 && errors == 0) begin
            errors++;
            $display("The test data file holds no rows");
        end
    endtask

    task automatic drive_step(input step_t s);
        cpu_bus[0]   = s.bus_a;
        cpu_bus[1]   = s.bus_b;
        rom_rdata[0] = s.rom_a;
        rom_rdata[1] = s.rom_b;
        {vbl, a_b, wba, wbb, vdg, rla, rlb} = s.ctl;
        v_in         = s.v_in;
    endtask

    task automatic check_status(input int i, input cpu_board_pkg::cpu_status_t exp);
        check_value($sformatf("status[%0d].din", i), 16'(exp.din), 16'(status[i].din));
        check_value($sformatf("status[%0d].irq_n", i), 16'(exp.irq_n),
                    16'(status[i].irq_n));
        check_value($sformatf("status[%0d].nmi_n", i), 16'(exp.nmi_n),
                    16'(status[i].nmi_n));
        check_value($sformatf("status[%0d].window_en", i), 16'(exp.window_en),
                    16'(status[i].window_en));
        check_value($sformatf("status[%0d].rom_bank", i), 16'(exp.rom_bank),
                    16'(status[i].rom_bank));
        check_value($sformatf("status[%0d].rom_cs", i), 16'(exp.rom_cs),
                    16'(status[i].rom_cs));
    endtask

    // Run limit
    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout, the run exceeded %0d cycles", cycle_limit);
            $display("TEST FAIL");
            $finish;
        end
    end

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        step_t idle;
        idle = '0;
        idle.bus_a.mreq_n = 1'b1;   // Bus control lines inactive
        idle.bus_a.rd_n   = 1'b1;
        idle.bus_a.wr_n   = 1'b1;
        idle.bus_a.iorq_n = 1'b1;
        idle.bus_b        = idle.bus_a;
        idle.ctl          = 7'b0011100; // wba, wbb, vdg high
        RESETn = 1'b0;
        drive_step(idle);
        load_steps();
        cycle_limit = 16 + 4 * steps.size() + 50;

        repeat (16) @(posedge clk);
        @(negedge clk);
        for (int i = 0; i < 2; i++) begin // State held in reset
            check_value($sformatf("status[%0d].din", i), 16'h00, 16'(status[i].din));
            check_value($sformatf("status[%0d].irq_n", i), 16'h1, 16'(status[i].irq_n));
            check_value($sformatf("status[%0d].nmi_n", i), 16'h1, 16'(status[i].nmi_n));
        end
        check_value("strobes", 16'h7F, 16'(strobes));
        RESETn = 1'b1;

        foreach (steps[k]) begin
            drive_step(steps[k]);
            @(posedge clk);
            #4;                          // Just before the next falling edge
            check_status(0, steps[k].exp_a);
            check_status(1, steps[k].exp_b);
            check_value("va", 16'(steps[k].exp_va), 16'(va));
            check_value("v_out", 16'(steps[k].exp_vo), 16'(v_out));
            check_value("strobes", 16'(steps[k].exp_st), 16'(strobes));
            @(negedge clk);
        end

        $display("Steps run: %0d, errors: %0d", steps.size(), errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/cpu_board_testdata.txt
# addr_a dout_a ctl_a addr_b dout_b ctl_b rom_a rom_b vbl a_b wba wbb vdg rla rlb v_in  (ctl = mreq_n rd_n wr_n iorq_n)
# then expected: din_a irq_a nmi_a win_a bank_a cs_a din_b irq_b nmi_b win_b bank_b cs_b va v_out strobes
0000 00 F 0000 00 F 00 00 0 0 1 1 1 1 0 5A  FF 1 1 0 0 0 FF 1 1 0 0 0 000 FF 7F
0000 00 F 0000 00 F 00 00 0 0 1 1 1 0 1 C3  FF 1 1 0 0 0 FF 1 1 0 0 0 000 FF 7F
D123 00 3 E456 00 3 00 00 0 0 1 1 1 0 0 99  5A 1 1 1 3 0 C3 1 1 1 3 0 123 FF 7F
4ABC 00 3 8001 00 3 77 66 0 1 1 1 1 0 0 00  77 1 1 0 1 1 66 1 1 0 2 1 001 FF 7F
C300 00 3 2000 00 B 00 00 0 0 1 1 1 0 0 00  FF 1 1 0 3 0 FF 1 1 0 0 0 300 FF 7F
0000 00 F 0000 00 F 00 00 1 0 1 1 1 0 0 00  FF 0 1 0 0 0 FF 0 1 0 0 0 000 FF 7F
0000 00 E 0000 00 F 00 00 1 0 1 1 1 0 0 00  FF 1 1 0 0 0 FF 0 1 0 0 0 000 FF 7F
0000 00 F 0000 00 E 00 00 0 0 1 1 1 0 0 00  FF 1 1 0 0 0 FF 1 1 0 0 0 000 FF 7F
0000 00 E 0000 00 F 00 00 1 0 1 1 1 0 0 00  FF 1 1 0 0 0 FF 0 1 0 0 0 000 FF 7F
0000 00 F 0000 00 E 00 00 0 0 1 1 1 0 0 00  FF 1 1 0 0 0 FF 1 1 0 0 0 000 FF 7F
C700 00 3 0000 00 F 00 00 0 0 1 1 1 0 0 00  FF 1 1 0 3 0 FF 1 1 0 0 0 700 FF 7F
0000 00 F 0000 00 F 00 00 0 0 1 1 1 0 0 00  FF 1 1 0 0 0 FF 1 0 0 0 0 000 FF 7F
0000 00 F C000 11 5 00 00 0 0 1 1 1 0 0 00  FF 1 1 0 0 0 FF 1 1 0 3 0 000 FF 7F
0000 00 F C000 00 3 00 00 0 0 1 1 1 0 0 00  FF 1 1 0 0 0 FF 1 1 0 3 0 000 FF 7F
0000 00 F 0000 00 F 00 00 0 0 1 1 1 0 0 00  FF 1 0 0 0 0 FF 1 1 0 0 0 000 FF 7F
C700 22 5 0000 00 F 00 00 0 0 1 1 1 0 0 00  FF 1 1 0 3 0 FF 1 1 0 0 0 700 FF 7F
C800 12 F CD00 34 F 00 00 0 0 0 1 0 0 0 00  FF 1 1 0 3 0 FF 1 1 0 3 0 800 12 3F
C800 12 F CD00 34 F 00 00 0 1 1 0 0 0 0 00  FF 1 1 0 3 0 FF 1 1 0 3 0 D00 34 7F
C900 12 F CD00 34 F 00 00 0 0 0 0 0 0 0 00  FF 1 1 0 3 0 FF 1 1 0 3 0 900 12 5F
CA00 12 F CD00 34 F 00 00 0 0 1 1 0 0 0 00  FF 1 1 0 3 0 FF 1 1 0 3 0 A00 FF 6F
CB00 12 F CD00 34 F 00 00 0 0 1 1 0 0 0 00  FF 1 1 0 3 0 FF 1 1 0 3 0 B00 FF 77
CC00 12 F CD00 34 F 00 00 0 0 1 1 0 0 0 00  FF 1 1 0 3 0 FF 1 1 0 3 0 C00 FF 7B
CE00 12 F CD00 34 F 00 00 0 0 1 1 0 0 0 00  FF 1 1 0 3 0 FF 1 1 0 3 0 E00 FF 7D
CF00 12 F CD00 34 F 00 00 0 0 1 1 0 0 0 00  FF 1 1 0 3 0 FF 1 1 0 3 0 F00 FF 7E
CF00 12 F CD00 34 F 00 00 0 0 1 1 1 0 0 00  FF 1 1 0 3 0 FF 1 1 0 3 0 F00 FF 7F
CF00 12 F C800 34 F 00 00 0 1 1 1 0 0 0 00  FF 1 1 0 3 0 FF 1 1 0 3 0 800 FF 3F
0000 00 F 0000 00 F 00 00 0 0 1 1 1 0 0 00  FF 1 1 0 0 0 FF 1 1 0 0 0 000 FF 7F

// File: src.f
+incdir+include
rtl/cpu_board_pkg.sv
rtl/video_read_latch.sv
rtl/cpu_bus_port.sv
rtl/mailbox_nmi.sv
rtl/video_bus_mux.sv
rtl/cpu_board_glue.sv
verification/tb_clock_gen.sv
verification/tb_cpu_board_glue.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the CPU board glue testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_cpu_board_glue \
    -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
if [ $? -ne 0 ]; then
    cat sim.log
    echo "Simulation exited with an error"
    exit 1
fi
cat sim.log

if grep -q "^TEST PASS$" sim.log; then
    exit 0
else
    exit 1
fi
